// ==== Bender.yml ====
package:
  name: friscv_rv32i

sources:
  - friscv_pkg.sv
  - friscv_fetch.sv
  - friscv_decoder.sv
  - friscv_registers.sv
  - friscv_alu.sv
  - friscv_writeback.sv
  - friscv_rv32i.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - friscv_rv32i_tb.sv

// ==== friscv_alu.sv ====
//////////////////////////////////////////////////
// Execute stage: ALU operations, BEQ/BNE/JAL resolution
// and effective address of LW/SW with GPIO window check
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_alu import friscv_pkg::*; (
    input  opcode_t         opcode,
    input  alu_op_t         alu_op,
    input  logic            is_bne,
    input  logic            use_imm,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    output logic [XLEN-1:0] alu_result,
    output logic            branch_taken,
    output logic [XLEN-1:0] jump_target,
    output logic [XLEN-1:0] mem_addr,
    output logic            gpio_hit
);

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            rs_equal;

    // Second operand is either rs2 or the I-type immediate
    assign op_b  = use_imm ? imm : rs2_val;
    assign shamt = op_b[4:0];

    assign lt_signed   = $signed(rs1_val) < $signed(op_b);
    assign lt_unsigned = rs1_val < op_b;

    always_comb begin
        case (alu_op)
            alu_sub:  alu_result = rs1_val - op_b;
            alu_and:  alu_result = rs1_val & op_b;
            alu_or:   alu_result = rs1_val | op_b;
            alu_xor:  alu_result = rs1_val ^ op_b;
            alu_sll:  alu_result = rs1_val << shamt;
            alu_srl:  alu_result = rs1_val >> shamt;
            alu_sra:  alu_result = $unsigned($signed(rs1_val) >>> shamt);
            alu_slt:  alu_result = {{(XLEN-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  alu_result = rs1_val + op_b;
        endcase
    end

    ////////////////////////////////////////////////// Control flow

    assign rs_equal    = (rs1_val == rs2_val);
    assign jump_target = pc + imm;

    always_comb begin
        case (opcode)
            op_jal:    branch_taken = 1'b1;
            op_branch: branch_taken = is_bne ? !rs_equal : rs_equal;
            default:   branch_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////// Load/store address

    assign mem_addr = rs1_val + imm;
    // Anything outside the window is dropped by writeback
    assign gpio_hit = (mem_addr >= GPIO_BASE_ADDR)
                      && (mem_addr < GPIO_BASE_ADDR + GPIO_SIZE);

endmodule

`default_nettype wire

// ==== friscv_decoder.sv ====
//////////////////////////////////////////////////
// Instruction decoder: splits the held instruction into
// opcode class, ALU operation, register indices and immediate
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_decoder import friscv_pkg::*; (
    input  logic [INSTR_W-1:0]    instr,
    output opcode_t               opcode,
    output alu_op_t               alu_op,
    output result_sel_t           result_sel,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output logic [XLEN-1:0]       imm,
    output logic                  use_imm,
    output logic                  rd_wr,
    output logic                  is_store,
    output logic                  is_load,
    output logic                  is_bne,
    output logic                  is_ebreak
);

    opcode_t         raw_op;
    logic [2:0]      funct3;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign raw_op   = opcode_t'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign rd_addr  = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign is_bne    = (raw_op == op_branch) && funct3[0];
    assign is_ebreak = (raw_op == op_system) && (instr[31:20] == 12'd1)
                       && (instr[19:7] == '0);

    always_comb begin
        opcode     = raw_op;
        alu_op     = alu_add;
        result_sel = res_alu;
        imm        = imm_i;
        use_imm    = 1'b0;
        rd_wr      = 1'b0;
        is_store   = 1'b0;
        is_load    = 1'b0;
        case (raw_op)
            op_lui: begin
                rd_wr      = 1'b1;
                result_sel = res_upper;
                imm        = imm_u;
            end
            op_jal: begin
                rd_wr      = 1'b1;
                result_sel = res_link;
                imm        = imm_j;
            end
            op_branch: begin
                imm = imm_b;
                // Only BEQ and BNE, other compares become a no-op
                if (funct3[2:1] != 2'b00) opcode = opcode_t'(7'h00);
            end
            op_load: begin
                rd_wr      = 1'b1;
                is_load    = 1'b1;
                result_sel = res_gpio;
            end
            op_store: begin
                is_store = 1'b1;
                imm      = imm_s;
            end
            op_imm, op_reg: begin
                rd_wr   = 1'b1;
                use_imm = (raw_op == op_imm);
                case (funct3)
                    3'b000:  alu_op = (raw_op == op_reg && instr[30]) ? alu_sub : alu_add;
                    3'b001:  alu_op = alu_sll;
                    3'b010:  alu_op = alu_slt;
                    3'b011:  alu_op = alu_sltu;
                    3'b100:  alu_op = alu_xor;
                    3'b101:  alu_op = instr[30] ? alu_sra : alu_srl;
                    3'b110:  alu_op = alu_or;
                    default: alu_op = alu_and;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== friscv_fetch.sv ====
//////////////////////////////////////////////////
// Fetch sequencer: drives the instruction read channel,
// holds the current instruction, the pc and the ebreak flag
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_fetch import friscv_pkg::*; (
    input  logic               aclk,
    input  logic               rst_n,
    input  logic               enable,
    // Instruction read channel
    output logic               inst_arvalid,
    input  logic               inst_arready,
    output logic [XLEN-1:0]    inst_araddr,
    input  logic               inst_rvalid,
    output logic               inst_rready,
    input  logic [XLEN-1:0]    inst_rdata,
    // From the execute stage
    input  logic               branch_taken,
    input  logic [XLEN-1:0]    jump_target,
    input  logic               is_ebreak,
    // To decode, execute and result stages
    output logic [INSTR_W-1:0] instr,
    output logic [XLEN-1:0]    pc,
    output logic               exec,
    output logic               ebreak
);

    fetch_state_t state;

    assign inst_arvalid = (state == s_addr);
    assign inst_araddr  = pc;
    assign inst_rready  = (state == s_data);
    assign exec         = (state == s_exec);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= s_idle;
            pc     <= BOOT_ADDR;
            ebreak <= 1'b0;
        end else begin
            case (state)
                s_idle: if (enable && !ebreak) state <= s_addr;
                s_addr: if (inst_arready) state <= s_data;
                s_data: if (inst_rvalid) state <= s_exec;
                s_exec: begin
                    pc <= branch_taken ? jump_target : pc + XLEN'(4);
                    // EBREAK parks the sequencer for good
                    if (is_ebreak) begin
                        ebreak <= 1'b1;
                        state  <= s_idle;
                    end else if (enable) begin
                        state <= s_addr;
                    end else begin
                        state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Instruction captured on the data transfer
    always_ff @(posedge aclk) begin
        if (inst_rvalid && inst_rready) instr <= inst_rdata;
    end

    // The read address must not move while the memory stalls it
    araddr_stable: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_arvalid && !inst_arready |=> inst_arvalid && $stable(inst_araddr));

endmodule

`default_nettype wire

// ==== friscv_pkg.sv ====
//////////////////////////////////////////////////
// Shared constants and enums of the RV32I core,
// imported by every RTL module of the design
//////////////////////////////////////////////////

`default_nettype none

package friscv_pkg;

    //////////////////////////////////////////////////
    // Architecture

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    // First fetch address after reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

    //////////////////////////////////////////////////
    // GPIO window reached by LW and SW

    localparam logic [XLEN-1:0] GPIO_BASE_ADDR = 32'd2048;
    localparam logic [XLEN-1:0] GPIO_SIZE      = 32'd8;

    //////////////////////////////////////////////////
    // Decode enums

    // Major opcodes, encoded as in the RV32I spec
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    // Source of the value written to rd
    typedef enum logic [1:0] {
        res_alu,
        res_gpio,
        res_link,
        res_upper
    } result_sel_t;

    typedef enum logic [1:0] {
        s_idle,
        s_addr,
        s_data,
        s_exec
    } fetch_state_t;

endpackage

`default_nettype wire

// ==== friscv_registers.sv ====
//////////////////////////////////////////////////
// ISA register file x0 to x31, two read ports, one write port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_registers import friscv_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [XLEN-1:0]       rs1_val,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [XLEN-1:0]       rs2_val,
    input  logic                  rd_wr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic [XLEN-1:0]       rd_val
);

    // x0 is not stored
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) regs[i] <= '0;
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_val;
        end
    end

    assign rs1_val = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== friscv_rv32i.f ====
+incdir+.
friscv_pkg.sv
friscv_fetch.sv
friscv_decoder.sv
friscv_registers.sv
friscv_alu.sv
friscv_writeback.sv
friscv_rv32i.sv
friscv_rv32i_tb.sv

// ==== friscv_rv32i.sv ====
//////////////////////////////////////////////////
// RV32I core top: fetch, decode, execute and result stages
// around the register file, with the instruction read channel and GPIO
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_rv32i import friscv_pkg::*; (
    input  logic            aclk,
    input  logic            rst_n,
    // Gates new fetches
    input  logic            enable,
    output logic            ebreak,
    // Instruction memory
    output logic            inst_arvalid,
    input  logic            inst_arready,
    output logic [XLEN-1:0] inst_araddr,
    input  logic            inst_rvalid,
    output logic            inst_rready,
    input  logic [XLEN-1:0] inst_rdata,
    // GPIO
    input  logic [XLEN-1:0] gpio_in,
    output logic [XLEN-1:0] gpio_out
);

    logic [INSTR_W-1:0]    instr;
    logic [XLEN-1:0]       pc;
    logic                  exec;
    opcode_t               opcode;
    alu_op_t               alu_op;
    result_sel_t           result_sel;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       imm;
    logic                  use_imm;
    logic                  rd_wr;
    logic                  is_store;
    logic                  is_load;
    logic                  is_bne;
    logic                  is_ebreak;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       alu_result;
    logic                  branch_taken;
    logic [XLEN-1:0]       jump_target;
    logic                  gpio_hit;
    logic                  reg_wr;
    logic [XLEN-1:0]       rd_val;

    //////////////////////////////////////////////////
    // Fetch sequencer

    friscv_fetch fetch (
        .aclk         (aclk        ),
        .rst_n        (rst_n       ),
        .enable       (enable      ),
        .inst_arvalid (inst_arvalid),
        .inst_arready (inst_arready),
        .inst_araddr  (inst_araddr ),
        .inst_rvalid  (inst_rvalid ),
        .inst_rready  (inst_rready ),
        .inst_rdata   (inst_rdata  ),
        .branch_taken (branch_taken),
        .jump_target  (jump_target ),
        .is_ebreak    (is_ebreak   ),
        .instr        (instr       ),
        .pc           (pc          ),
        .exec         (exec        ),
        .ebreak       (ebreak      )
    );

    friscv_decoder decoder (
        .instr      (instr     ),
        .opcode     (opcode    ),
        .alu_op     (alu_op    ),
        .result_sel (result_sel),
        .rs1_addr   (rs1_addr  ),
        .rs2_addr   (rs2_addr  ),
        .rd_addr    (rd_addr   ),
        .imm        (imm       ),
        .use_imm    (use_imm   ),
        .rd_wr      (rd_wr     ),
        .is_store   (is_store  ),
        .is_load    (is_load   ),
        .is_bne     (is_bne    ),
        .is_ebreak  (is_ebreak )
    );

    friscv_registers isa_registers (
        .aclk     (aclk    ),
        .rst_n    (rst_n   ),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val ),
        .rs2_addr (rs2_addr),
        .rs2_val  (rs2_val ),
        .rd_wr    (reg_wr  ),
        .rd_addr  (rd_addr ),
        .rd_val   (rd_val  )
    );

    //////////////////////////////////////////////////
    // Execute and result

    friscv_alu alu (
        .opcode       (opcode      ),
        .alu_op       (alu_op      ),
        .is_bne       (is_bne      ),
        .use_imm      (use_imm     ),
        .imm          (imm         ),
        .pc           (pc          ),
        .rs1_val      (rs1_val     ),
        .rs2_val      (rs2_val     ),
        .alu_result   (alu_result  ),
        .branch_taken (branch_taken),
        .jump_target  (jump_target ),
        .mem_addr     (            ),
        .gpio_hit     (gpio_hit    )
    );

    friscv_writeback writeback (
        .aclk       (aclk      ),
        .rst_n      (rst_n     ),
        .exec       (exec      ),
        .result_sel (result_sel),
        .rd_wr      (rd_wr     ),
        .is_load    (is_load   ),
        .is_store   (is_store  ),
        .gpio_hit   (gpio_hit  ),
        .alu_result (alu_result),
        .imm        (imm       ),
        .pc         (pc        ),
        .rs2_val    (rs2_val   ),
        .gpio_in    (gpio_in   ),
        .reg_wr     (reg_wr    ),
        .rd_val     (rd_val    ),
        .gpio_out   (gpio_out  )
    );

endmodule

`default_nettype wire

// ==== friscv_tb_program.svh ====
//////////////////////////////////////////////////
// Test program of the core testbench, with the gpio_out values
// and the fetch trace expected from it. Included inside the testbench module
//////////////////////////////////////////////////

`ifndef FRISCV_TB_PROGRAM_SVH
`define FRISCV_TB_PROGRAM_SVH

    localparam int              PROG_LEN   = 35;
    localparam int              BEQ_IDX    = 19;
    localparam int              JAL_IDX    = 24;
    localparam int              OPND_A     = 100;
    localparam int              OPND_B     = -7;
    localparam int              ORI_MASK   = 'h300;
    localparam int              FALL_VALUE = 'h55;
    localparam int              GPIO_ADD   = 'h123;
    localparam int              MISS_ADD   = 'h77;
    // Marker held in x13, stored only by skipped or out-of-window SW
    localparam int              MARK_UPPER = 'hDEAD5;
    localparam logic [XLEN-1:0] MARK_VALUE = {MARK_UPPER[19:0], 12'h000};

    // Result of the ALU chain in words 0 to 14, by the RV32I rules
    function automatic logic [XLEN-1:0] alu_chain_value();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] sra;
        logic [XLEN-1:0] x;
        a   = OPND_A;
        b   = OPND_B;
        sra = $signed(b) >>> 1;
        x   = ((a + b) ^ (a - b)) | ORI_MASK;
        x   = x << 4;
        x   = x + sra;
        x   = x + (b >> 28);
        x   = x + XLEN'($signed(b) < $signed(a));
        x   = x + XLEN'(b < a);
        return x;
    endfunction

    task automatic load_program();
        // Unused words hold ADDI x0 no-ops tagged with their own index
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = itype_word(i, 0, 0, 0, op_imm);
        end
        // ALU chain, result in x6
        imem[0]  = itype_word(OPND_A, 0, 0, 1, op_imm);
        imem[1]  = itype_word(OPND_B, 0, 0, 2, op_imm);
        imem[2]  = rtype_word(0, 2, 1, 0, 3);
        imem[3]  = rtype_word('h20, 2, 1, 0, 4);
        imem[4]  = rtype_word(0, 4, 3, 4, 5);
        imem[5]  = itype_word(ORI_MASK, 5, 6, 5, op_imm);
        imem[6]  = itype_word(4, 5, 1, 6, op_imm);
        imem[7]  = itype_word('h401, 2, 5, 7, op_imm);
        imem[8]  = itype_word(28, 2, 5, 8, op_imm);
        imem[9]  = rtype_word(0, 1, 2, 2, 9);
        imem[10] = rtype_word(0, 1, 2, 3, 10);
        imem[11] = rtype_word(0, 7, 6, 0, 6);
        imem[12] = rtype_word(0, 8, 6, 0, 6);
        imem[13] = rtype_word(0, 9, 6, 0, 6);
        imem[14] = rtype_word(0, 10, 6, 0, 6);
        // x11 = GPIO base through LUI and a negative ADDI
        imem[15] = utype_word(1, 11, op_lui);
        imem[16] = itype_word(-2048, 11, 0, 11, op_imm);
        imem[17] = stype_word(0, 6, 11);
        // Control flow
        imem[18]          = utype_word(MARK_UPPER, 13, op_lui);
        imem[BEQ_IDX]     = btype_word(8, 1, 1, 0);
        imem[BEQ_IDX + 1] = stype_word(0, 13, 11);
        imem[21]          = btype_word(8, 1, 1, 1);
        imem[22]          = itype_word(FALL_VALUE, 0, 0, 14, op_imm);
        imem[23]          = stype_word(0, 14, 11);
        imem[JAL_IDX]     = jtype_word(8, 15);
        imem[JAL_IDX + 1] = stype_word(0, 13, 11);
        imem[26]          = stype_word(0, 15, 11);
        // GPIO load and store, then a store and a load outside the window
        imem[27] = itype_word(4, 11, 2, 12, op_load);
        imem[28] = itype_word(GPIO_ADD, 12, 0, 12, op_imm);
        imem[29] = stype_word(0, 12, 11);
        imem[30] = stype_word(16, 13, 11);
        imem[31] = itype_word(16, 11, 2, 16, op_load);
        imem[32] = itype_word(MISS_ADD, 16, 0, 16, op_imm);
        imem[33] = stype_word(0, 16, 11);
        imem[34] = itype_word(1, 0, 0, 0, op_system);
        // Taken BEQ and JAL each skip the word after them
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i != BEQ_IDX + 1 && i != JAL_IDX + 1) trace.push_back(BOOT_ADDR + 4 * i);
        end
    endtask

`endif

// ==== friscv_rv32i_tb.sv ====
//////////////////////////////////////////////////
// Testbench of the RV32I core: instruction memory with random back-pressure,
// gpio_out checks against the program and a check of the fetch trace
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_rv32i_tb import friscv_pkg::*; ();

    localparam int IMEM_WORDS        = 64;
    localparam int ENABLE_OFF_AT     = 10;
    localparam int ENABLE_OFF_CYCLES = 12;
    localparam int HALT_CYCLES       = 20;

    logic            aclk;
    logic            rst_n;
    logic            enable;
    logic            ebreak;
    logic            inst_arvalid;
    logic            inst_arready;
    logic [XLEN-1:0] inst_araddr;
    logic            inst_rvalid;
    logic            inst_rready;
    logic [XLEN-1:0] inst_rdata;
    logic [XLEN-1:0] gpio_in;
    logic [XLEN-1:0] gpio_out;

    integer          seed = 56513;
    int              errors;
    int              tests_run;
    int              fetch_count;
    int              stall_cycles;
    int              cycles;
    int              addr_wait;
    int              data_wait;
    logic            data_pending;
    logic            enable_toggled;
    logic [XLEN-1:0] req_addr;
    logic [XLEN-1:0] imem [0:IMEM_WORDS-1];
    logic [XLEN-1:0] trace [$];

    ////////////////////////////////////////////////// Instruction encoders

    function automatic logic [31:0] itype_word(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] rtype_word(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] stype_word(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype_word(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype_word(int imm20, int rd, logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] jtype_word(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    `include "friscv_tb_program.svh"

    // Worst case of about 10 cycles per instruction plus the pauses
    localparam int CYCLE_LIMIT = PROG_LEN * 10 + ENABLE_OFF_CYCLES + HALT_CYCLES + 100;

    ////////////////////////////////////////////////// Checks and reporting

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] expected);
        assert (got == expected)
        else begin
            $display("FAILED %s: got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_fetch(input logic [XLEN-1:0] addr);
        if (fetch_count < trace.size()) begin
            compare_word("inst_araddr", addr, trace[fetch_count]);
        end else begin
            $display("Fetch beyond the end of the program at address %h", addr);
            errors++;
        end
        fetch_count++;
    endtask

    task automatic wait_gpio_change(output logic [XLEN-1:0] value);
        logic [XLEN-1:0] last;
        last = gpio_out;
        @(negedge aclk);
        while (gpio_out == last) @(negedge aclk);
        value = gpio_out;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    endtask

    friscv_rv32i i_friscv_rv32i (
        .aclk         (aclk        ),
        .rst_n        (rst_n       ),
        .enable       (enable      ),
        .ebreak       (ebreak      ),
        .inst_arvalid (inst_arvalid),
        .inst_arready (inst_arready),
        .inst_araddr  (inst_araddr ),
        .inst_rvalid  (inst_rvalid ),
        .inst_rready  (inst_rready ),
        .inst_rdata   (inst_rdata  ),
        .gpio_in      (gpio_in     ),
        .gpio_out     (gpio_out    )
    );

    initial begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Instruction memory, 0 to 3 cycles of delay on each handshake
    always @(negedge aclk) begin
        if (rst_n) begin
            if (inst_rvalid) begin
                inst_rvalid = 1'b0;
            end else if (data_pending) begin
                if (data_wait == 0) begin
                    inst_rvalid  = 1'b1;
                    inst_rdata   = imem[req_addr[7:2]];
                    data_pending = 1'b0;
                end else begin
                    data_wait--;
                    stall_cycles++;
                end
            end
            // arready was high over the last rising edge, so the address was taken
            if (inst_arready) begin
                inst_arready = 1'b0;
                data_pending = 1'b1;
                data_wait    = $random(seed) & 3;
            end else if (inst_arvalid) begin
                if (addr_wait == 0) begin
                    inst_arready = 1'b1;
                    req_addr     = inst_araddr;
                    check_fetch(inst_araddr);
                    addr_wait    = $random(seed) & 3;
                end else begin
                    addr_wait--;
                    stall_cycles++;
                end
            end
        end
    end

    // Fetch gate, closed for a while in the middle of the program
    initial begin
        enable         = 1'b1;
        enable_toggled = 1'b0;
        wait (fetch_count == ENABLE_OFF_AT);
        @(negedge aclk);
        enable = 1'b0;
        repeat (ENABLE_OFF_CYCLES) @(negedge aclk);
        enable         = 1'b1;
        enable_toggled = 1'b1;
    end

    ////////////////////////////////////////////////// Protocol assertions

    araddr_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        inst_arvalid && !inst_arready |=> inst_arvalid && $stable(inst_araddr))
    else begin
        $display("Fetch address or arvalid moved while arready was low");
        errors++;
    end

    no_fetch_disabled: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(inst_arvalid) |-> $past(enable))
    else begin
        $display("A fetch started while enable was low");
        errors++;
    end

    halt_sticky: assert property (@(posedge aclk) disable iff (!rst_n)
        ebreak |=> ebreak && !inst_arvalid)
    else begin
        $display("The core left the halt after EBREAK");
        errors++;
    end

    no_marker: assert property (@(posedge aclk) gpio_out != MARK_VALUE)
    else begin
        $display("FAILED gpio_out: got %h from a skipped or out-of-window store", gpio_out);
        errors++;
    end

    ////////////////////////////////////////////////// Test sequence

    initial begin
        int              errors_before;
        logic [XLEN-1:0] value;
        rst_n        = 1'b0;
        inst_arready = 1'b0;
        inst_rvalid  = 1'b0;
        inst_rdata   = '0;
        data_pending = 1'b0;
        gpio_in      = $random(seed);
        addr_wait    = $random(seed) & 3;
        load_program();

        errors_before = errors;
        repeat (2) @(negedge aclk);
        compare_word("inst_arvalid", XLEN'(inst_arvalid), '0);
        compare_word("inst_rready", XLEN'(inst_rready), '0);
        compare_word("ebreak", XLEN'(ebreak), '0);
        compare_word("gpio_out", gpio_out, '0);
        repeat (2) @(negedge aclk);
        rst_n = 1'b1;
        // First fetch is compared with the boot address in the trace
        while (fetch_count == 0) @(negedge aclk);
        report_test("reset and boot address", errors_before);

        errors_before = errors;
        wait_gpio_change(value);
        compare_word("gpio_out", value, alu_chain_value());
        report_test("ALU group", errors_before);

        errors_before = errors;
        wait_gpio_change(value);
        compare_word("gpio_out", value, FALL_VALUE);
        wait_gpio_change(value);
        compare_word("gpio_out", value, BOOT_ADDR + 4 * JAL_IDX + 4);
        report_test("BEQ, BNE and JAL", errors_before);

        errors_before = errors;
        wait_gpio_change(value);
        compare_word("gpio_out", value, gpio_in + GPIO_ADD);
        // The store outside the window in between must not show up here
        wait_gpio_change(value);
        compare_word("gpio_out", value, MISS_ADD);
        report_test("GPIO load and store", errors_before);

        errors_before = errors;
        while (!ebreak) @(negedge aclk);
        if (fetch_count != trace.size()) begin
            $display("Saw %0d fetches where the program makes %0d", fetch_count, trace.size());
            errors++;
        end
        if (stall_cycles == 0) begin
            $display("No handshake was ever delayed");
            errors++;
        end
        report_test("fetch trace under back-pressure", errors_before);

        errors_before = errors;
        repeat (HALT_CYCLES) @(negedge aclk);
        compare_word("ebreak", XLEN'(ebreak), 1);
        if (!enable_toggled) begin
            $display("The enable pause never took place");
            errors++;
        end
        report_test("halt and enable", errors_before);

        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout after %0d cycles before the program ended", cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== friscv_writeback.sv ====
//////////////////////////////////////////////////
// Result stage: picks the rd value, writes the register
// file during exec and holds the GPIO output register
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module friscv_writeback import friscv_pkg::*; (
    input  logic            aclk,
    input  logic            rst_n,
    input  logic            exec,
    input  result_sel_t     result_sel,
    input  logic            rd_wr,
    input  logic            is_load,
    input  logic            is_store,
    input  logic            gpio_hit,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs2_val,
    input  logic [XLEN-1:0] gpio_in,
    output logic            reg_wr,
    output logic [XLEN-1:0] rd_val,
    output logic [XLEN-1:0] gpio_out
);

    logic gpio_wr;

    always_comb begin
        case (result_sel)
            res_gpio:  rd_val = (is_load && gpio_hit) ? gpio_in : '0;
            res_link:  rd_val = pc + XLEN'(4);
            res_upper: rd_val = imm;
            default:   rd_val = alu_result;
        endcase
    end

    assign reg_wr  = exec && rd_wr;
    assign gpio_wr = exec && is_store && gpio_hit;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) gpio_out <= '0;
        else if (gpio_wr) gpio_out <= rs2_val;
    end

    // One register write per instruction, and a store never writes rd
    reg_wr_single: assert property (@(posedge aclk) disable iff (!rst_n)
        reg_wr |=> !reg_wr);
    store_no_reg_wr: assert property (@(posedge aclk) disable iff (!rst_n)
        exec && is_store |-> !reg_wr);

endmodule

`default_nettype wire
